// ==== dma_top.f ====
rtl/dma_pkg.sv
rtl/dma_fifo.sv
rtl/dma_burst_ctrl.sv
rtl/dma_apb_regs.sv
rtl/dma_top.sv
sim/tb_dma_top.sv

// ==== Makefile ====
SIM  := obj_dir/Vtb_dma_top
SRCS := $(wildcard rtl/*.sv) sim/tb_dma_top.sv

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) dma_top.f
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_dma_top \
		-f dma_top.f -o Vtb_dma_top

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "All tests passed" sim.log
	! grep -q "Some tests failed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_dma_top.sv ====
module tb_dma_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam dma_pkg::dma_status_t ST_CLEAR    = '0;
    localparam dma_pkg::dma_status_t ST_DONE     = '{busy: 1'b0, done: 1'b1, err: 1'b0};
    localparam dma_pkg::dma_status_t ST_DONE_ERR = '{busy: 1'b0, done: 1'b1, err: 1'b1};

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    dma_pkg::apb_req_t  apb_req = '0;
    dma_pkg::apb_rsp_t  apb_rsp;
    logic               arready = 1'b1;
    logic               awready = 1'b1;
    logic               wready = 1'b0;
    dma_pkg::axi_r_t    r_ch = '0;
    dma_pkg::axi_b_t    b_ch = '0;
    dma_pkg::axi_ar_t   ar_ch;
    dma_pkg::axi_aw_t   aw_ch;
    dma_pkg::axi_w_t    w_ch;
    logic               rready;
    logic               bready;
    logic               irq;

    // slave memory model state
    logic [31:0]        mem [4096];
    logic [11:0]        rd_addr;
    logic [11:0]        wr_addr;
    int                 rd_left;
    int                 ar_lens[$];
    int                 aw_lens[$];
    integer             seed = 32'h41c0_6bc1;
    logic               stall = 1'b0;
    logic [1:0]         b_resp = 2'b00;

    int                 checks = 0;
    int                 errors = 0;
    logic [31:0]        rdata;
    logic               slverr;

    always #50 clk = ~clk;

    dma_top #(
        .FIFO_DEPTH (4),
        .MAX_BURST  (16)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .apb_i     (apb_req),
        .arready_i (arready),
        .awready_i (awready),
        .wready_i  (wready),
        .r_i       (r_ch),
        .b_i       (b_ch),
        .apb_o     (apb_rsp),
        .ar_o      (ar_ch),
        .aw_o      (aw_ch),
        .w_o       (w_ch),
        .rready_o  (rready),
        .bready_o  (bready),
        .irq_o     (irq)
    );

    // AXI slave memory addressed in words by addr[13:2]
    always @(posedge clk) begin : axi_slave
        int          left;
        logic [11:0] addr;
        logic        drop;
        if (rst) begin
            for (int i = 0; i < 4096; i++)
                mem[i] <= $random(seed);
            r_ch     <= '0;
            b_ch     <= '0;
            wready   <= 1'b0;
            rd_left  <= 0;
        end else begin
            left = rd_left;
            addr = rd_addr;
            if (r_ch.valid && rready) begin
                left = left - 1;
                addr = addr + 1'b1;
            end
            if (ar_ch.valid && arready) begin
                left = ar_ch.len + 1;
                addr = ar_ch.addr[13:2];
                ar_lens.push_back(ar_ch.len + 1);
            end
            rd_left <= left;
            rd_addr <= addr;
            drop = stall && (($random(seed) & 3) == 0);
            // a raised rvalid holds its beat until taken
            if (!r_ch.valid || rready) begin
                if (left > 0 && !drop)
                    r_ch <= {mem[addr], 2'b00, left == 1, 1'b1};
                else
                    r_ch <= '0;
            end
            if (aw_ch.valid && awready) begin
                wr_addr <= aw_ch.addr[13:2];
                aw_lens.push_back(aw_ch.len + 1);
            end
            if (b_ch.valid && bready)
                b_ch.valid <= 1'b0;
            if (w_ch.valid && wready) begin
                mem[wr_addr] <= w_ch.data;
                wr_addr      <= wr_addr + 1'b1;
                if (w_ch.last)
                    b_ch <= {b_resp, 1'b1};
            end
            wready <= !(stall && (($random(seed) & 1) != 0));
        end
    end

    task automatic abort_run(input string what);
        $display("Timed out: %s at %0t", what, $time);
        $display("checks %0d errors %0d", checks, errors);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic check_word(input string name, input logic [dma_pkg::DATA_W-1:0] exp,
                              input logic [dma_pkg::DATA_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input dma_pkg::dma_status_t exp,
                                input dma_pkg::dma_status_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // setup phase, access phase, then wait for pready
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] data,
                              output logic err);
        int n;
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!apb_rsp.pready && n < 16);
        if (!apb_rsp.pready)
            abort_run("APB access got no pready");
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        apb_req <= '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        apb_access(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic wait_idle(output dma_pkg::dma_status_t st);
        int n;
        n  = 0;
        st = '{busy: 1'b1, done: 1'b0, err: 1'b0};
        while (st.busy && n < 1000) begin
            apb_read(dma_pkg::REG_STATUS, rdata, slverr);
            st = rdata[2:0];
            n++;
        end
        if (st.busy)
            abort_run("transfer still busy");
    endtask

    task automatic program_copy(input int src_w, input int dst_w, input int len,
                                input logic [31:0] ctrl);
        // clear done and err first
        apb_write(dma_pkg::REG_STATUS, 32'h3, slverr);
        apb_write(dma_pkg::REG_SRC, 32'(src_w * 4), slverr);
        apb_write(dma_pkg::REG_DST, 32'(dst_w * 4), slverr);
        apb_write(dma_pkg::REG_LEN, 32'(len), slverr);
        apb_write(dma_pkg::REG_CTRL, ctrl, slverr);
    endtask

    task automatic copy_and_check(input int src_w, input int dst_w, input int len,
                                  input logic [31:0] ctrl);
        logic [31:0]          expect_q[$];
        logic [31:0]          guard;
        dma_pkg::dma_status_t st;
        for (int i = 0; i < len; i++)
            expect_q.push_back(mem[src_w + i]);
        guard = mem[dst_w + len];
        program_copy(src_w, dst_w, len, ctrl);
        wait_idle(st);
        check_status("status", ST_DONE, st);
        for (int i = 0; i < len; i++)
            check_word($sformatf("dst[%0d]", i), expect_q[i], mem[dst_w + i]);
        check_word("word after dst", guard, mem[dst_w + len]);
    endtask

    task automatic registers_and_errors;
        dma_pkg::dma_status_t st;
        check_word("reset outputs", 32'd0,
                   32'({ar_ch.valid, aw_ch.valid, w_ch.valid, rready, bready, irq}));
        apb_read(dma_pkg::REG_STATUS, rdata, slverr);
        check_status("reset status", ST_CLEAR, rdata[2:0]);
        apb_write(dma_pkg::REG_SRC, 32'h0000_0100, slverr);
        apb_write(dma_pkg::REG_DST, 32'h0000_2000, slverr);
        apb_write(dma_pkg::REG_LEN, 32'd5, slverr);
        apb_read(dma_pkg::REG_SRC, rdata, slverr);
        check_word("SRC", 32'h0000_0100, rdata);
        apb_read(dma_pkg::REG_DST, rdata, slverr);
        check_word("DST", 32'h0000_2000, rdata);
        apb_read(dma_pkg::REG_LEN, rdata, slverr);
        check_word("LEN", 32'd5, rdata);
        apb_read(8'h14, rdata, slverr);
        check_word("pslverr unmapped", 32'd1, 32'(slverr));
        apb_write(dma_pkg::REG_CTRL, 32'h1, slverr);
        // LEN is locked while the copy runs
        apb_write(dma_pkg::REG_LEN, 32'd99, slverr);
        check_word("pslverr busy", 32'd1, 32'(slverr));
        wait_idle(st);
        apb_read(dma_pkg::REG_LEN, rdata, slverr);
        check_word("LEN after busy write", 32'd5, rdata);
    endtask

    task automatic short_copy;
        copy_and_check(12'h060, 12'h880, 5, 32'h3);
        @(posedge clk);
        check_word("irq_o", 32'd1, 32'(irq));
        apb_write(dma_pkg::REG_CTRL, 32'h0, slverr);
        @(posedge clk);
        check_word("irq_o masked", 32'd0, 32'(irq));
        apb_write(dma_pkg::REG_CTRL, 32'h2, slverr);
        @(posedge clk);
        check_word("irq_o unmasked", 32'd1, 32'(irq));
    endtask

    task automatic multi_burst_copy;
        int base_ar;
        int base_aw;
        base_ar = ar_lens.size();
        base_aw = aw_lens.size();
        copy_and_check(12'h100, 12'hC00, 37, 32'h1);
        check_word("ar bursts", 32'd3, 32'(ar_lens.size() - base_ar));
        check_word("aw bursts", 32'd3, 32'(aw_lens.size() - base_aw));
        if (ar_lens.size() - base_ar == 3) begin
            check_word("ar beats 0", 32'd16, 32'(ar_lens[base_ar]));
            check_word("ar beats 1", 32'd16, 32'(ar_lens[base_ar + 1]));
            check_word("ar beats 2", 32'd5, 32'(ar_lens[base_ar + 2]));
        end
        if (aw_lens.size() - base_aw == 3) begin
            check_word("aw beats 0", 32'd16, 32'(aw_lens[base_aw]));
            check_word("aw beats 1", 32'd16, 32'(aw_lens[base_aw + 1]));
            check_word("aw beats 2", 32'd5, 32'(aw_lens[base_aw + 2]));
        end
    endtask

    task automatic backpressure_copy;
        stall = 1'b1;
        copy_and_check(12'h200, 12'hD00, 40, 32'h1);
        stall = 1'b0;
    endtask

    task automatic status_clear;
        int                   n_ar;
        int                   n_aw;
        dma_pkg::dma_status_t st;
        n_ar = ar_lens.size();
        n_aw = aw_lens.size();
        program_copy(12'h300, 12'hE00, 0, 32'h3);
        wait_idle(st);
        check_status("zero length status", ST_DONE, st);
        check_word("ar bursts", 32'(n_ar), 32'(ar_lens.size()));
        check_word("aw bursts", 32'(n_aw), 32'(aw_lens.size()));
        @(posedge clk);
        check_word("irq_o", 32'd1, 32'(irq));
        apb_write(dma_pkg::REG_STATUS, 32'h2, slverr);
        @(posedge clk);
        check_word("irq_o after clear", 32'd0, 32'(irq));
        apb_read(dma_pkg::REG_STATUS, rdata, slverr);
        check_status("status after clear", ST_CLEAR, rdata[2:0]);
    endtask

    task automatic error_response;
        dma_pkg::dma_status_t st;
        b_resp = 2'b10;
        program_copy(12'h300, 12'hE00, 3, 32'h1);
        wait_idle(st);
        b_resp = 2'b00;
        check_status("slverr status", ST_DONE_ERR, st);
        // clearing err leaves done set
        apb_write(dma_pkg::REG_STATUS, 32'h1, slverr);
        apb_read(dma_pkg::REG_STATUS, rdata, slverr);
        check_status("err cleared", ST_DONE, rdata[2:0]);
    endtask

    initial begin
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        registers_and_errors();
        short_copy();
        multi_burst_copy();
        backpressure_copy();
        status_clear();
        error_response();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== rtl/dma_top.sv ====
module dma_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int MAX_BURST  = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  dma_pkg::apb_req_t  apb_i,
    input  logic               arready_i,
    input  logic               awready_i,
    input  logic               wready_i,
    input  dma_pkg::axi_r_t    r_i,
    input  dma_pkg::axi_b_t    b_i,
    output dma_pkg::apb_rsp_t  apb_o,
    output dma_pkg::axi_ar_t   ar_o,
    output dma_pkg::axi_aw_t   aw_o,
    output dma_pkg::axi_w_t    w_o,
    output logic               rready_o,
    output logic               bready_o,
    output logic               irq_o
);

    dma_pkg::dma_desc_t desc;
    logic               start;
    logic               busy;
    logic               fin;
    logic               err;
    logic               wr_en;
    logic               last_beat;

    dma_apb_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .apb_i   (apb_i),
        .busy_i  (busy),
        .fin_i   (fin),
        .err_i   (err),
        .apb_o   (apb_o),
        .desc_o  (desc),
        .start_o (start),
        .irq_o   (irq_o)
    );

    dma_burst_ctrl #(
        .MAX_BURST (MAX_BURST)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start),
        .desc_i      (desc),
        .arready_i   (arready_i),
        .awready_i   (awready_i),
        .r_i         (r_i),
        .b_i         (b_i),
        .last_beat_i (last_beat),
        .ar_o        (ar_o),
        .aw_o        (aw_o),
        .bready_o    (bready_o),
        .wr_en_o     (wr_en),
        .busy_o      (busy),
        .fin_o       (fin),
        .err_o       (err)
    );

    // write burst length follows the AW request
    dma_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk         (clk),
        .rst         (rst),
        .clr_i       (fin),
        .r_i         (r_i),
        .wr_en_i     (wr_en),
        .wready_i    (wready_i),
        .burst_len_i (aw_o.len),
        .rready_o    (rready_o),
        .w_o         (w_o),
        .last_beat_o (last_beat)
    );

endmodule

// ==== rtl/dma_apb_regs.sv ====
module dma_apb_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  dma_pkg::apb_req_t    apb_i,
    input  logic                 busy_i,
    input  logic                 fin_i,
    input  logic                 err_i,
    output dma_pkg::apb_rsp_t    apb_o,
    output dma_pkg::dma_desc_t   desc_o,
    output logic                 start_o,
    output logic                 irq_o
);

    logic                access;
    logic                wr;
    logic                hit_src;
    logic                hit_dst;
    logic                hit_len;
    logic                hit_ctrl;
    logic                hit_status;
    logic                mapped;
    logic                desc_wr;
    logic                irq_en_q;
    logic                done_q;
    logic                err_q;
    dma_pkg::dma_desc_t  desc_q;
    dma_pkg::dma_status_t status;

    // zero wait states so the access phase completes at once
    assign access = apb_i.psel && apb_i.penable;
    assign wr     = access && apb_i.pwrite;

    assign hit_src    = apb_i.paddr == dma_pkg::REG_SRC;
    assign hit_dst    = apb_i.paddr == dma_pkg::REG_DST;
    assign hit_len    = apb_i.paddr == dma_pkg::REG_LEN;
    assign hit_ctrl   = apb_i.paddr == dma_pkg::REG_CTRL;
    assign hit_status = apb_i.paddr == dma_pkg::REG_STATUS;
    assign mapped     = hit_src || hit_dst || hit_len || hit_ctrl || hit_status;

    // descriptor is locked while a transfer runs
    assign desc_wr = wr && !busy_i;

    assign start_o = wr && hit_ctrl && apb_i.pwdata[0] && !busy_i;

    assign status.busy = busy_i;
    assign status.done = done_q;
    assign status.err  = err_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            desc_q   <= '0;
            irq_en_q <= 1'b0;
        end else begin
            if (desc_wr && hit_src)
                desc_q.src <= apb_i.pwdata;
            if (desc_wr && hit_dst)
                desc_q.dst <= apb_i.pwdata;
            if (desc_wr && hit_len)
                desc_q.len <= apb_i.pwdata[dma_pkg::LEN_W-1:0];
            if (wr && hit_ctrl)
                irq_en_q <= apb_i.pwdata[1];
        end
    end

    // a new event wins over a clear of the sticky flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_q <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            if (fin_i)
                done_q <= 1'b1;
            else if (wr && hit_status && apb_i.pwdata[1])
                done_q <= 1'b0;
            if (err_i)
                err_q <= 1'b1;
            else if (wr && hit_status && apb_i.pwdata[0])
                err_q <= 1'b0;
        end
    end

    always_comb begin
        apb_o.prdata = '0;
        if (hit_src)
            apb_o.prdata = desc_q.src;
        else if (hit_dst)
            apb_o.prdata = desc_q.dst;
        else if (hit_len)
            apb_o.prdata = dma_pkg::DATA_W'(desc_q.len);
        else if (hit_ctrl)
            apb_o.prdata = dma_pkg::DATA_W'({irq_en_q, 1'b0});
        else if (hit_status)
            apb_o.prdata = dma_pkg::DATA_W'(status);
    end

    assign apb_o.pready  = access;
    assign apb_o.pslverr = access && (!mapped ||
                           (wr && busy_i && (hit_src || hit_dst || hit_len)));

    assign desc_o = desc_q;
    assign irq_o  = done_q && irq_en_q;

endmodule

// ==== rtl/dma_burst_ctrl.sv ====
module dma_burst_ctrl #(
    parameter int MAX_BURST = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start_i,
    input  dma_pkg::dma_desc_t  desc_i,
    input  logic                arready_i,
    input  logic                awready_i,
    input  dma_pkg::axi_r_t     r_i,
    input  dma_pkg::axi_b_t     b_i,
    input  logic                last_beat_i,
    output dma_pkg::axi_ar_t    ar_o,
    output dma_pkg::axi_aw_t    aw_o,
    output logic                bready_o,
    output logic                wr_en_o,
    output logic                busy_o,
    output logic                fin_o,
    output logic                err_o
);

    typedef enum logic [2:0] {
        IDLE,
        CHECK,
        AR,
        AW,
        DATA,
        RESP,
        FIN
    } state_t;

    state_t                       state_q;
    state_t                       state_d;
    logic [dma_pkg::LEN_W-1:0]    rem_q;
    logic [7:0]                   blen_q;
    logic [dma_pkg::ADDR_W-1:0]   src_q;
    logic [dma_pkg::ADDR_W-1:0]   dst_q;
    logic                         err_q;
    logic [8:0]                   beats;
    logic [dma_pkg::ADDR_W-1:0]   step;
    logic                         b_hs;

    assign beats = {1'b0, blen_q} + 9'd1;
    // four bytes per beat
    assign step  = dma_pkg::ADDR_W'(beats) << 2;
    assign b_hs  = bready_o && b_i.valid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:  if (start_i) state_d = CHECK;
            CHECK: state_d = (rem_q == '0) ? FIN : AR;
            AR:    if (arready_i) state_d = AW;
            AW:    if (awready_i) state_d = DATA;
            DATA:  if (last_beat_i) state_d = RESP;
            RESP:  if (b_i.valid) state_d = CHECK;
            FIN:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rem_q  <= '0;
            blen_q <= '0;
        end else if (state_q == IDLE && start_i) begin
            rem_q <= desc_i.len;
        end else if (state_q == CHECK) begin
            // next burst is the smaller of remaining words and MAX_BURST
            if (rem_q >= dma_pkg::LEN_W'(MAX_BURST))
                blen_q <= 8'(MAX_BURST - 1);
            else
                blen_q <= 8'(rem_q - 1'b1);
        end else if (b_hs) begin
            rem_q <= rem_q - dma_pkg::LEN_W'(beats);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            src_q <= desc_i.src;
            dst_q <= desc_i.dst;
        end else if (b_hs) begin
            src_q <= src_q + step;
            dst_q <= dst_q + step;
        end
    end

    // collect any error response over the whole transfer
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            err_q <= 1'b0;
        else if (state_q == IDLE && start_i)
            err_q <= 1'b0;
        else if (state_q == DATA && r_i.valid && r_i.resp != 2'b00)
            err_q <= 1'b1;
        else if (b_hs && b_i.resp != 2'b00)
            err_q <= 1'b1;
    end

    assign ar_o.addr  = src_q;
    assign ar_o.len   = blen_q;
    assign ar_o.valid = state_q == AR;

    assign aw_o.addr  = dst_q;
    assign aw_o.len   = blen_q;
    assign aw_o.valid = state_q == AW;

    assign wr_en_o  = state_q == DATA;
    assign bready_o = state_q == RESP;
    assign busy_o   = state_q != IDLE;
    assign fin_o    = state_q == FIN;
    assign err_o    = fin_o && err_q;

endmodule

// ==== rtl/dma_fifo.sv ====
module dma_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              clr_i,
    input  dma_pkg::axi_r_t   r_i,
    input  logic              wr_en_i,
    input  logic              wready_i,
    input  logic [7:0]        burst_len_i,
    output logic              rready_o,
    output dma_pkg::axi_w_t   w_o,
    output logic              last_beat_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [dma_pkg::DATA_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           count;
    logic [7:0]                 beat_cnt;
    logic                       full;
    logic                       empty;
    logic                       push;
    logic                       pop;

    assign full  = count == CNT_W'(FIFO_DEPTH);
    assign empty = count == '0;

    // R is only taken during the data phase of a burst
    assign rready_o = wr_en_i && !full;
    assign push     = r_i.valid && rready_o;

    assign w_o.data  = mem[rd_ptr];
    assign w_o.valid = wr_en_i && !empty;
    assign w_o.last  = beat_cnt == burst_len_i;
    assign pop       = w_o.valid && wready_i;

    assign last_beat_o = pop && w_o.last;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= r_i.data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            beat_cnt <= '0;
        end else if (clr_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            beat_cnt <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
            // beat counter restarts for each burst
            if (pop)
                beat_cnt <= w_o.last ? 8'd0 : beat_cnt + 8'd1;
        end
    end

endmodule

// ==== rtl/dma_pkg.sv ====
package dma_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int LEN_W  = 16;

    // register byte offsets
    localparam logic [7:0] REG_SRC    = 8'h00;
    localparam logic [7:0] REG_DST    = 8'h04;
    localparam logic [7:0] REG_LEN    = 8'h08;
    localparam logic [7:0] REG_CTRL   = 8'h0C;
    localparam logic [7:0] REG_STATUS = 8'h10;

    typedef struct packed {
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        logic [LEN_W-1:0]  len;   // in words
    } dma_desc_t;

    typedef struct packed {
        logic busy;
        logic done;
        logic err;
    } dma_status_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [7:0]        paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;   // beats minus one
        logic              valid;
    } axi_ar_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic              valid;
    } axi_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
        logic              valid;
    } axi_w_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
        logic              valid;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
        logic       valid;
    } axi_b_t;

endpackage
